// File: tests/tlul_intg_cases.txt
# valid instr_type address opcode mask write_data cmd_intg data_intg, all in hex
# Codes are the inverted Hsiao check bits of the packed command and of the write data
1 6 00000000 0 f 00000000 34 2a
1 9 00000000 4 f 00000001 71 33
1 6 00000004 1 1 0000000f 55 32
0 9 deadbeef 4 3 12345678 00 00
1 6 00000008 0 f 000000ff 1d 5b
1 9 00000010 1 3 80000000 5e 78
1 6 0000000c 4 f 90000001 11 2b
1 9 0000001c 0 f 000000a5 1d 0b
1 6 0000001f 1 3 00000000 5e 2a

// File: files.f
+incdir+rtl
rtl/tlul_intg_pkg.sv
rtl/tlul_a_if.sv
rtl/secded_inv_64_57_enc.sv
rtl/secded_inv_39_32_enc.sv
rtl/tlul_cmd_intg_gen.sv
rtl/tlul_data_intg_gen.sv
rtl/tlul_a_chan_reg.sv
rtl/tlul_host_intg_top.sv
tests/tlul_host_intg_checker.sv
tests/tb_tlul_host_intg.sv

// File: Bender.yml
package:
  name: tlul_host_intg

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tlul_intg_pkg.sv
      - rtl/tlul_a_if.sv
      - rtl/secded_inv_64_57_enc.sv
      - rtl/secded_inv_39_32_enc.sv
      - rtl/tlul_cmd_intg_gen.sv
      - rtl/tlul_data_intg_gen.sv
      - rtl/tlul_a_chan_reg.sv
      - rtl/tlul_host_intg_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tlul_host_intg_checker.sv
      - tests/tb_tlul_host_intg.sv

// File: tests/tb_tlul_host_intg.sv
// ************************************************************************
// Testbench for the TL-UL host request integrity top level
// Replays requests from the cases file and compares every registered beat
// and both check codes with the expected values of each case
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "tlul_intg_cfg.svh"

module tb_tlul_host_intg;
    import tlul_intg_pkg::*;

    localparam int ClkPeriodNs  = 100;
    localparam int DriveDelayNs = 10;
    localparam int ResetCycles  = 4;

    logic                          clk_i;
    logic                          reset_i;
    logic                          req_valid_i;
    mubi4_t                        req_instr_type_i;
    logic [`TLUL_AW-1:0]           req_addr_i;
    tl_a_op_e                      req_opcode_i;
    logic [`TLUL_DBW-1:0]          req_mask_i;
    logic [`TLUL_DW-1:0]           req_data_i;
    logic                          a_valid_o;
    mubi4_t                        a_instr_type_o;
    tl_a_op_e                      a_opcode_o;
    logic [`TLUL_AW-1:0]           a_address_o;
    logic [`TLUL_DBW-1:0]          a_mask_o;
    logic [`TLUL_DW-1:0]           a_data_o;
    logic [`TLUL_CMD_INTG_W-1:0]   a_cmd_intg_o;
    logic [`TLUL_DATA_INTG_W-1:0]  a_data_intg_o;

    // One entry per line of the cases file
    logic                          cs_valid[$];
    mubi4_t                        cs_instr[$];
    logic [`TLUL_AW-1:0]           cs_addr[$];
    tl_a_op_e                      cs_op[$];
    logic [`TLUL_DBW-1:0]          cs_mask[$];
    logic [`TLUL_DW-1:0]           cs_data[$];
    logic [`TLUL_CMD_INTG_W-1:0]   cs_cmd[$];
    logic [`TLUL_DATA_INTG_W-1:0]  cs_dintg[$];

    // Last beat that the A channel should be showing
    mubi4_t                        exp_instr;
    tl_a_op_e                      exp_op;
    logic [`TLUL_AW-1:0]           exp_addr;
    logic [`TLUL_DBW-1:0]          exp_mask;
    logic [`TLUL_DW-1:0]           exp_data;
    logic [`TLUL_CMD_INTG_W-1:0]   exp_cmd;
    logic [`TLUL_DATA_INTG_W-1:0]  exp_dintg;

    int seed = 97;
    bit cases_loaded = 1'b0;

    tlul_host_intg_top tlul_host_intg_top_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #(ClkPeriodNs / 2) clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        abort_run("Output mismatch on the A channel");
    endtask

    task automatic verify_valid(input logic exp_valid);
        if (a_valid_o !== exp_valid) report_value("a_valid_o", a_valid_o, exp_valid);
    endtask

    task automatic check_beat(input mubi4_t e_instr, input tl_a_op_e e_op,
                              input logic [`TLUL_AW-1:0] e_addr,
                              input logic [`TLUL_DBW-1:0] e_mask,
                              input logic [`TLUL_DW-1:0] e_data);
        if (a_instr_type_o !== e_instr) report_value("a_instr_type_o", a_instr_type_o, e_instr);
        if (a_opcode_o !== e_op) report_value("a_opcode_o", a_opcode_o, e_op);
        if (a_address_o !== e_addr) report_value("a_address_o", a_address_o, e_addr);
        if (a_mask_o !== e_mask) report_value("a_mask_o", a_mask_o, e_mask);
        if (a_data_o !== e_data) report_value("a_data_o", a_data_o, e_data);
    endtask

    task automatic check_intg(input logic [`TLUL_CMD_INTG_W-1:0] e_cmd,
                              input logic [`TLUL_DATA_INTG_W-1:0] e_dintg);
        if (a_cmd_intg_o !== e_cmd) report_value("a_cmd_intg_o", a_cmd_intg_o, e_cmd);
        if (a_data_intg_o !== e_dintg) report_value("a_data_intg_o", a_data_intg_o, e_dintg);
    endtask

    task automatic load_cases();
        int fd;
        int code;
        string line;
        logic [31:0] v, it, ad, op, mk, dt, ci, di;
        fd = $fopen("tests/tlul_intg_cases.txt", "r");
        if (fd == 0) abort_run("The cases file could not be opened");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // Comment lines start with a hash and blank lines give too few fields
            if (code != 0 && line.len() > 0 && line[0] != "#") begin
                code = $sscanf(line, "%h %h %h %h %h %h %h %h", v, it, ad, op, mk, dt, ci, di);
                if (code == 8) begin
                    cs_valid.push_back(v[0]);
                    cs_instr.push_back(mubi4_t'(it[3:0]));
                    cs_addr.push_back(ad);
                    cs_op.push_back(tl_a_op_e'(op[2:0]));
                    cs_mask.push_back(mk[3:0]);
                    cs_data.push_back(dt);
                    cs_cmd.push_back(ci[6:0]);
                    cs_dintg.push_back(di[6:0]);
                end
            end
        end
        $fclose(fd);
        if (cs_valid.size() == 0) abort_run("The cases file holds no cases");
    endtask

    // Idle cycle with junk on the fields, which must not reach the outputs
    task automatic drive_idle();
        req_valid_i      = 1'b0;
        req_instr_type_i = MuBi4False;
        req_addr_i       = $random(seed);
        req_opcode_i     = Get;
        req_mask_i       = $random(seed);
        req_data_i       = $random(seed);
    endtask

    task automatic advance_and_compare(input logic exp_valid);
        @(posedge clk_i);
        #DriveDelayNs;
        verify_valid(exp_valid);
        check_beat(exp_instr, exp_op, exp_addr, exp_mask, exp_data);
        check_intg(exp_cmd, exp_dintg);
    endtask

    // The watchdog allows four cycles per case and the reset time on top
    initial begin
        wait (cases_loaded);
        #((cs_valid.size() * 4 + ResetCycles) * ClkPeriodNs);
        abort_run("Timeout, the run did not complete in time");
    end

    // Watch the assertion failures of the bound checker
    initial begin
        wait (tlul_host_intg_top_i.u_a_chan_reg.u_checker.fail_count != 0);
        abort_run("An assertion on the A-channel outputs failed");
    end

    initial begin
        int fill;
        reset_i = 1'b1;
        drive_idle();
        load_cases();
        cases_loaded = 1'b1;
        repeat (ResetCycles) @(posedge clk_i);
        #DriveDelayNs;
        reset_i = 1'b0;
        // Reset leaves every output at zero
        exp_instr = mubi4_t'(4'h0);
        exp_op    = PutFullData;
        exp_addr  = '0;
        exp_mask  = '0;
        exp_data  = '0;
        exp_cmd   = '0;
        exp_dintg = '0;
        verify_valid(1'b0);
        check_beat(exp_instr, exp_op, exp_addr, exp_mask, exp_data);
        check_intg(exp_cmd, exp_dintg);
        for (int i = 0; i < cs_valid.size(); i++) begin
            req_valid_i      = cs_valid[i];
            req_instr_type_i = cs_instr[i];
            req_addr_i       = cs_addr[i];
            req_opcode_i     = cs_op[i];
            req_mask_i       = cs_mask[i];
            req_data_i       = cs_data[i];
            if (cs_valid[i]) begin
                exp_instr = cs_instr[i];
                exp_op    = cs_op[i];
                exp_addr  = cs_addr[i];
                exp_mask  = cs_mask[i];
                exp_data  = cs_data[i];
                exp_cmd   = cs_cmd[i];
                exp_dintg = cs_dintg[i];
            end
            advance_and_compare(cs_valid[i]);
            // Pairs of cases go back to back and are followed by a few random idle cycles
            if (i % 2 == 1) begin
                fill = {$random(seed)} % 4;
                repeat (fill) begin
                    drive_idle();
                    advance_and_compare(1'b0);
                end
            end
        end
        drive_idle();
        advance_and_compare(1'b0);
        $display(">>> PASS");
        $finish;
    end

endmodule : tb_tlul_host_intg

`default_nettype wire

// File: tests/tlul_host_intg_checker.sv
// ************************************************************************
// TL-UL A-channel output assertions
// Reset state, valid timing, disabled data code and known outputs
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "tlul_intg_cfg.svh"

module tlul_host_intg_checker #(
    parameter bit EnableDataIntgGen = `TLUL_DATA_INTG_EN
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          req_valid_i,
    input  logic                          a_valid_o,
    input  logic [3:0]                    a_instr_type_o,
    input  logic [2:0]                    a_opcode_o,
    input  logic [`TLUL_AW-1:0]           a_address_o,
    input  logic [`TLUL_DBW-1:0]          a_mask_o,
    input  logic [`TLUL_DW-1:0]           a_data_o,
    input  logic [`TLUL_CMD_INTG_W-1:0]   a_cmd_intg_o,
    input  logic [`TLUL_DATA_INTG_W-1:0]  a_data_intg_o
);

    // Count of failed assertions
    int unsigned fail_count = 0;

    // The beat is gone in the cycle after a reset
    valid_low_after_reset: assert property (@(posedge clk_i) reset_i |=> !a_valid_o)
        else begin
            $error("a_valid_o high after reset");
            fail_count++;
        end

    // Valid is the request strobe delayed by one register stage
    valid_follows_req: assert property (@(posedge clk_i)
        (!reset_i && $past(!reset_i)) |-> (a_valid_o == $past(req_valid_i)))
        else begin
            $error("a_valid_o does not follow the request strobe");
            fail_count++;
        end

    // Every output of a beat must be driven to a known value
    beat_known: assert property (@(posedge clk_i) disable iff (reset_i)
        a_valid_o |-> !$isunknown({a_instr_type_o, a_opcode_o, a_address_o, a_mask_o,
                                   a_data_o, a_cmd_intg_o, a_data_intg_o}))
        else begin
            $error("unknown bits on an A-channel beat");
            fail_count++;
        end

    if (!EnableDataIntgGen) begin : gen_no_data_intg_check
        // Without the encoder the data code stays zero
        data_intg_zero: assert property (@(posedge clk_i) a_data_intg_o == '0)
            else begin
                $error("data code not zero with data integrity disabled");
                fail_count++;
            end
    end

endmodule : tlul_host_intg_checker

bind tlul_a_chan_reg tlul_host_intg_checker u_checker (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_valid_i    (req.valid),
    .a_valid_o      (a_valid_o),
    .a_instr_type_o (a_instr_type_o),
    .a_opcode_o     (a_opcode_o),
    .a_address_o    (a_address_o),
    .a_mask_o       (a_mask_o),
    .a_data_o       (a_data_o),
    .a_cmd_intg_o   (a_cmd_intg_o),
    .a_data_intg_o  (a_data_intg_o)
);

`default_nettype wire

// File: rtl/tlul_host_intg_top.sv
// ************************************************************************
// TL-UL host request integrity top level
// Turns a plain host command into a registered A-channel beat carrying
// command and data integrity, one cycle after the request
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "tlul_intg_cfg.svh"

module tlul_host_intg_top #(
    parameter bit EnableDataIntgGen = `TLUL_DATA_INTG_EN
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          req_valid_i,
    input  tlul_intg_pkg::mubi4_t         req_instr_type_i,
    input  logic [`TLUL_AW-1:0]           req_addr_i,
    input  tlul_intg_pkg::tl_a_op_e       req_opcode_i,
    input  logic [`TLUL_DBW-1:0]          req_mask_i,
    input  logic [`TLUL_DW-1:0]           req_data_i,
    output logic                          a_valid_o,
    output tlul_intg_pkg::mubi4_t         a_instr_type_o,
    output tlul_intg_pkg::tl_a_op_e       a_opcode_o,
    output logic [`TLUL_AW-1:0]           a_address_o,
    output logic [`TLUL_DBW-1:0]          a_mask_o,
    output logic [`TLUL_DW-1:0]           a_data_o,
    output logic [`TLUL_CMD_INTG_W-1:0]   a_cmd_intg_o,
    output logic [`TLUL_DATA_INTG_W-1:0]  a_data_intg_o
);

    logic [`TLUL_CMD_INTG_W-1:0]  cmd_intg;
    logic [`TLUL_DATA_INTG_W-1:0] data_intg;

    // Request bundle shared by the generators and the output register
    tlul_a_if req_if ();

    assign req_if.valid      = req_valid_i;
    assign req_if.instr_type = req_instr_type_i;
    assign req_if.addr       = req_addr_i;
    assign req_if.opcode     = req_opcode_i;
    assign req_if.mask       = req_mask_i;
    assign req_if.data       = req_data_i;

    // Both codes are combinational and settle in the request cycle
    tlul_cmd_intg_gen u_cmd_intg_gen (
        .req        (req_if.dst),
        .cmd_intg_o (cmd_intg)
    );

    tlul_data_intg_gen #(
        .EnableDataIntgGen (EnableDataIntgGen)
    ) u_data_intg_gen (
        .req         (req_if.dst),
        .data_intg_o (data_intg)
    );

    tlul_a_chan_reg u_a_chan_reg (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req            (req_if.dst),
        .cmd_intg_i     (cmd_intg),
        .data_intg_i    (data_intg),
        .a_valid_o      (a_valid_o),
        .a_instr_type_o (a_instr_type_o),
        .a_opcode_o     (a_opcode_o),
        .a_address_o    (a_address_o),
        .a_mask_o       (a_mask_o),
        .a_data_o       (a_data_o),
        .a_cmd_intg_o   (a_cmd_intg_o),
        .a_data_intg_o  (a_data_intg_o)
    );

endmodule : tlul_host_intg_top

`default_nettype wire

// File: rtl/tlul_a_chan_reg.sv
// ************************************************************************
// TL-UL A-channel output register
// Captures a request and both integrity codes in the same clock edge so
// that the beat leaves the host with fields and codes aligned
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "tlul_intg_cfg.svh"

module tlul_a_chan_reg (
    input  logic                          clk_i,
    input  logic                          reset_i,
    tlul_a_if.dst                         req,
    input  logic [`TLUL_CMD_INTG_W-1:0]   cmd_intg_i,
    input  logic [`TLUL_DATA_INTG_W-1:0]  data_intg_i,
    output logic                          a_valid_o,
    output tlul_intg_pkg::mubi4_t         a_instr_type_o,
    output tlul_intg_pkg::tl_a_op_e       a_opcode_o,
    output logic [`TLUL_AW-1:0]           a_address_o,
    output logic [`TLUL_DBW-1:0]          a_mask_o,
    output logic [`TLUL_DW-1:0]           a_data_o,
    output logic [`TLUL_CMD_INTG_W-1:0]   a_cmd_intg_o,
    output logic [`TLUL_DATA_INTG_W-1:0]  a_data_intg_o
);
    import tlul_intg_pkg::*;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            a_valid_o      <= 1'b0;
            a_instr_type_o <= mubi4_t'(4'h0);
            a_opcode_o     <= PutFullData;
            a_address_o    <= '0;
            a_mask_o       <= '0;
            a_data_o       <= '0;
            a_cmd_intg_o   <= '0;
            a_data_intg_o  <= '0;
        end else begin
            // Valid follows the request strobe with one cycle of delay
            a_valid_o <= req.valid;
            // Payload only moves on a request, idle cycles keep the last beat
            if (req.valid) begin
                a_instr_type_o <= req.instr_type;
                a_opcode_o     <= req.opcode;
                a_address_o    <= req.addr;
                a_mask_o       <= req.mask;
                a_data_o       <= req.data;
                a_cmd_intg_o   <= cmd_intg_i;
                a_data_intg_o  <= data_intg_i;
            end
        end
    end

endmodule : tlul_a_chan_reg

`default_nettype wire

// File: rtl/tlul_data_intg_gen.sv
// ************************************************************************
// TL-UL data integrity generator
// Returns the check bits of the inverted (39,32) code over the write data,
// or zeros when data integrity is disabled
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "tlul_intg_cfg.svh"

module tlul_data_intg_gen #(
    parameter bit EnableDataIntgGen = `TLUL_DATA_INTG_EN
) (
    tlul_a_if.dst                         req,
    output logic [`TLUL_DATA_INTG_W-1:0]  data_intg_o
);

    if (EnableDataIntgGen) begin : gen_data_intg
        logic [`TLUL_DW+`TLUL_DATA_INTG_W-1:0] data_word;

        // Code is computed for every cycle, the output register picks it up
        // only together with a valid request
        secded_inv_39_32_enc u_data_enc (
            .data_i (req.data),
            .data_o (data_word)
        );

        assign data_intg_o = data_word[`TLUL_DW+`TLUL_DATA_INTG_W-1:`TLUL_DW];
    end else begin : gen_no_data_intg
        // No encoder is built; the device side must not check data then
        assign data_intg_o = '0;
    end

endmodule : tlul_data_intg_gen

`default_nettype wire

// File: rtl/tlul_cmd_intg_gen.sv
// ************************************************************************
// TL-UL command integrity generator
// Packs the command fields of a request and returns the seven check bits
// of the inverted (64,57) code over them
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "tlul_intg_cfg.svh"

module tlul_cmd_intg_gen (
    tlul_a_if.dst                        req,
    output logic [`TLUL_CMD_INTG_W-1:0]  cmd_intg_o
);
    import tlul_intg_pkg::*;

    tl_h2d_cmd_intg_t             cmd;
    logic [`TLUL_CMD_MAX_W-1:0]   cmd_ext;
    logic [63:0]                  cmd_word;

    // Field order follows the struct, instruction type in the top bits
    assign cmd = '{
        instr_type: req.instr_type,
        addr:       req.addr,
        opcode:     req.opcode,
        mask:       req.mask
    };

    // The 43-bit command is zero-extended to the encoder width
    assign cmd_ext = `TLUL_CMD_MAX_W'(cmd);

    secded_inv_64_57_enc u_cmd_enc (
        .data_i (cmd_ext),
        .data_o (cmd_word)
    );

    // Only the check bits leave; the echoed command bits are not needed
    assign cmd_intg_o = cmd_word[63:`TLUL_CMD_MAX_W];

endmodule : tlul_cmd_intg_gen

`default_nettype wire

// File: rtl/secded_inv_39_32_enc.sv
// ************************************************************************
// Inverted Hsiao SECDED (39,32) encoder
// Passes 32 data bits through and appends seven inverted check bits
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

module secded_inv_39_32_enc (
    input  logic [31:0] data_i,
    output logic [38:0] data_o
);

    // An all-zero data word encodes to exactly this pattern
    localparam logic [6:0] InvPattern = 7'h2A;

    logic [6:0] check;

    // Parity over the seven Hsiao rows of the (39,32) code
    assign check[0] = ^(data_i & 32'h2606BD25);
    assign check[1] = ^(data_i & 32'hDEBA8050);
    assign check[2] = ^(data_i & 32'h413D89AA);
    assign check[3] = ^(data_i & 32'h31234ED1);
    assign check[4] = ^(data_i & 32'hC2C1323B);
    assign check[5] = ^(data_i & 32'h2DCC624C);
    assign check[6] = ^(data_i & 32'h98505586);

    assign data_o = {check ^ InvPattern, data_i};

endmodule : secded_inv_39_32_enc

`default_nettype wire

// File: rtl/secded_inv_64_57_enc.sv
// ************************************************************************
// Inverted Hsiao SECDED (64,57) encoder
// Passes 57 data bits through and appends seven inverted check bits
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

module secded_inv_64_57_enc (
    input  logic [56:0] data_i,
    output logic [63:0] data_o
);

    // Inversion keeps the all-zero word from being a valid codeword
    localparam logic [6:0] InvPattern = 7'h54;

    logic [6:0] check;

    // Each check bit is the parity over one Hsiao row of the H matrix
    // Every data column has an odd weight, which gives double error detection
    assign check[0] = ^(data_i & 57'h103FFF800007FFF);
    assign check[1] = ^(data_i & 57'h17C1FF801FF801F);
    assign check[2] = ^(data_i & 57'h1BDE1F87E0781E1);
    assign check[3] = ^(data_i & 57'h1DEEE3B8E388E22);
    assign check[4] = ^(data_i & 57'h1EF76CDB2C93244);
    assign check[5] = ^(data_i & 57'h1F7BB56D5525488);
    assign check[6] = ^(data_i & 57'h1FBDDA769A46910);

    // Data in the low bits, inverted check bits on top
    assign data_o = {check ^ InvPattern, data_i};

endmodule : secded_inv_64_57_enc

`default_nettype wire

// File: rtl/tlul_a_if.sv
// ************************************************************************
// TL-UL A-channel request bundle
// One host request as seen by the integrity generators and the A-channel
// output register
// ************************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "tlul_intg_cfg.svh"

interface tlul_a_if;
    import tlul_intg_pkg::*;

    // Request strobe; no ready exists, so every high cycle is a request
    logic                   valid;
    mubi4_t                 instr_type;
    logic [`TLUL_AW-1:0]    addr;
    tl_a_op_e               opcode;
    logic [`TLUL_DBW-1:0]   mask;
    logic [`TLUL_DW-1:0]    data;

    // Driving side, wired from the top-level ports
    modport src (output valid, instr_type, addr, opcode, mask, data);

    // Consuming side, shared by both generators and the output register
    modport dst (input valid, instr_type, addr, opcode, mask, data);

endinterface : tlul_a_if

`default_nettype wire

// File: rtl/tlul_intg_pkg.sv
// ************************************************************************
// TL-UL host integrity types
// Opcode encoding, multi-bit boolean and the packed command that is
// covered by the command integrity code
// ************************************************************************

`default_nettype none

`include "tlul_intg_cfg.svh"

package tlul_intg_pkg;

    // A-channel opcodes used by this host
    typedef enum logic [2:0] {
        PutFullData    = 3'h0,
        PutPartialData = 3'h1,
        Get            = 3'h4
    } tl_a_op_e;

    // Multi-bit boolean; every pattern other than these two is invalid
    typedef enum logic [3:0] {
        MuBi4True  = 4'h6,
        MuBi4False = 4'h9
    } mubi4_t;

    // Command fields protected by the command code, 43 bits in total
    // The instruction type sits in the top bits, the byte mask at the bottom
    typedef struct packed {
        mubi4_t                instr_type;
        logic [`TLUL_AW-1:0]   addr;
        tl_a_op_e              opcode;
        logic [`TLUL_DBW-1:0]  mask;
    } tl_h2d_cmd_intg_t;

endpackage : tlul_intg_pkg

`default_nettype wire

// File: rtl/tlul_intg_cfg.svh
// ************************************************************************
// TL-UL host integrity configuration
// Bus widths, check-code widths and the default data integrity enable
// ************************************************************************

`ifndef TLUL_INTG_CFG_SVH
`define TLUL_INTG_CFG_SVH

// Address, data and byte mask widths of the A channel
`define TLUL_AW 32
`define TLUL_DW 32
`define TLUL_DBW 4

// Check bits of the command code and of the data code
`define TLUL_CMD_INTG_W 7
`define TLUL_DATA_INTG_W 7

// Input width of the (64,57) command encoder
`define TLUL_CMD_MAX_W 57

// Data integrity is generated unless a module overrides this
`define TLUL_DATA_INTG_EN 1

`endif
